/* hdl/evr_defs.svh */
`ifndef EVR_DEFS_SVH
`define EVR_DEFS_SVH

// Segment image and slot counter
`define EVR_SEG_WORDS      32
`define EVR_SLOT_W         6
`define EVR_COMMA_PERIOD   4
`define EVR_BEACON_PERIOD  7

// Link characters
`define EVR_K28_5          8'hBC  // Comma, sent as K
`define EVR_BEACON         8'h7E  // Plain data byte
`define EVR_SEG_START      8'h5C
`define EVR_SEG_STOP       8'h3C

// Event path
`define EVR_EVT_W          8
`define EVR_PRESC_W        16
`define EVR_FIFO_DEPTH     16
`define EVR_FIFO_AW        4

`endif

/* hdl/evr_pkg.sv */
`include "evr_defs.svh"

package evr_pkg;

    // Link side
    typedef logic [`EVR_SLOT_W-1:0]  slot_t;
    typedef logic [7:0]              link_byte_t;
    typedef logic [15:0]             link_word_t;  // {event byte, data byte}
    typedef logic [1:0]              link_k_t;     // One K flag per byte

    // Event side
    typedef logic [`EVR_EVT_W-1:0]   evt_code_t;
    typedef logic [`EVR_PRESC_W-1:0] presc_t;

    // Needs one extra bit so a full FIFO reads as 16
    typedef logic [`EVR_FIFO_AW:0]   fifo_level_t;

endpackage

/* hdl/evr_test_top.sv */
`timescale 1ns/10ps

module evr_test_top
(
    input  logic                 clk,
    input  logic                 arst_n_i,

    // Link stream
    input  logic                 link_ready_i,
    output evr_pkg::link_word_t  tx_word_o,
    output evr_pkg::link_k_t     tx_is_k_o,

    // Test event source
    input  logic                 clear_i,
    input  evr_pkg::presc_t      presc_i,
    input  logic                 pop_i,
    output evr_pkg::evt_code_t   evt_code_o,   // FIFO head
    output logic                 evt_empty_o,
    output evr_pkg::fifo_level_t evt_level_o,
    output evr_pkg::evt_code_t   evt_next_o    // Next code to be pushed
);

    // Counter to FIFO
    evt_push_if push_if ();

    link_frame_gen u_link_frame_gen
    (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .link_ready_i (link_ready_i),
        .tx_word_o    (tx_word_o),
        .tx_is_k_o    (tx_is_k_o)
    );

    evt_prescaler u_evt_prescaler
    (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .clear_i    (clear_i),
        .presc_i    (presc_i),
        .push       (push_if.src),
        .evt_next_o (evt_next_o)
    );

    // Host drains through pop_i
    evt_fifo u_evt_fifo
    (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .pop_i       (pop_i),
        .push        (push_if.dst),
        .evt_code_o  (evt_code_o),
        .evt_empty_o (evt_empty_o),
        .evt_level_o (evt_level_o)
    );

endmodule

/* hdl/evt_fifo.sv */
`timescale 1ns/10ps

`include "evr_defs.svh"

module evt_fifo
(
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 pop_i,
    evt_push_if.dst              push,
    output evr_pkg::evt_code_t   evt_code_o,
    output logic                 evt_empty_o,
    output evr_pkg::fifo_level_t evt_level_o
);

    import evr_pkg::*;

    evt_code_t               mem [`EVR_FIFO_DEPTH];
    logic [`EVR_FIFO_AW-1:0] wr_ptr;
    logic [`EVR_FIFO_AW-1:0] rd_ptr;
    fifo_level_t             level;
    logic                    full;
    logic                    empty;
    logic                    do_push;
    logic                    do_pop;

    assign full  = (level == fifo_level_t'(`EVR_FIFO_DEPTH));
    assign empty = (level == '0);

    // Pop on empty is dropped here
    assign do_push = push.push && !full;
    assign do_pop  = pop_i && !empty;

    // Storage
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push.code;
        end
    end

    // Pointers and level, clear empties the FIFO
    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else if (push.clear)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;  // Idle, or push and pop together
            endcase
        end
    end

    assign push.full = full;

    // Head word falls through, pop only advances it
    assign evt_code_o  = mem[rd_ptr];
    assign evt_empty_o = empty;
    assign evt_level_o = level;

endmodule

/* hdl/evt_prescaler.sv */
`timescale 1ns/10ps

module evt_prescaler
(
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               clear_i,
    input  evr_pkg::presc_t    presc_i,
    evt_push_if.src            push,
    output evr_pkg::evt_code_t evt_next_o
);

    import evr_pkg::*;

    presc_t    cnt;
    evt_code_t code;
    logic      cnt_done;
    logic      fire;

    // Greater-or-equal also recovers when presc_i is lowered mid-count
    assign cnt_done = (cnt >= presc_i);

    // Stall while the FIFO is full, so no event is lost
    assign fire = cnt_done && !push.full && !clear_i;

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            cnt  <= '0;
            code <= '0;
        end
        else if (clear_i)
        begin
            cnt  <= '0;
            code <= '0;
        end
        else if (!push.full)
        begin
            if (cnt_done)
            begin
                cnt  <= '0;
                code <= code + 1'b1;  // Modulo 256
            end
            else
            begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign push.push  = fire;
    assign push.code  = code;   // Current code goes out with the strobe
    assign push.clear = clear_i;

    assign evt_next_o = code;

endmodule

/* hdl/evt_push_if.sv */
`timescale 1ns/10ps

// Event push strobe from the code counter into the FIFO
interface evt_push_if;

    logic               push;   // One cycle per event, only while full is low
    evr_pkg::evt_code_t code;
    logic               full;   // FIFO back-pressure
    logic               clear;  // Synchronous clear of the whole event path

    modport src
    (
        output push,
        output code,
        output clear,
        input  full
    );

    modport dst
    (
        input  push,
        input  code,
        input  clear,
        output full
    );

endinterface

/* hdl/link_frame_gen.sv */
`timescale 1ns/10ps

`include "evr_defs.svh"

module link_frame_gen
(
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                link_ready_i,
    output evr_pkg::link_word_t tx_word_o,
    output evr_pkg::link_k_t    tx_is_k_o
);

    import evr_pkg::*;

    // Segment image, one byte per odd slot
    localparam link_byte_t seg_image [`EVR_SEG_WORDS] = '{
        `EVR_SEG_START,                  // Segment start
        8'hFF,                           // Segment address
        8'h00, 8'h8B, 8'hFC, 8'h7B,
        8'h00, 8'h00, 8'h00, 8'h07,
        8'h00, 8'h00, 8'h00, 8'h00,
        8'h00, 8'h00, 8'h00, 8'h07,
        `EVR_SEG_STOP,                   // Segment stop
        8'hFC, 8'hF0,                    // Checksum
        8'h00, 8'h00, 8'h00, 8'h00,
        8'h00, 8'h00, 8'h00, 8'h00,
        8'h00, 8'h00, 8'h00
    };

    slot_t      slot;
    link_byte_t event_byte;
    link_byte_t data_byte;
    logic       event_is_k;
    logic       data_is_k;

    // Slot counter restarts whenever the link drops
    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            slot <= '0;
        end
        else if (!link_ready_i)
        begin
            slot <= '0;
        end
        else
        begin
            slot <= slot + 1'b1;  // Wraps at 64
        end
    end

    // Event byte: comma beats beacon when both periods hit
    always_comb
    begin
        event_byte = '0;
        if (!link_ready_i)
        begin
            event_byte = '0;
        end
        else if (slot % `EVR_COMMA_PERIOD == 0)
        begin
            event_byte = `EVR_K28_5;
        end
        else if (slot % `EVR_BEACON_PERIOD == 0)
        begin
            event_byte = `EVR_BEACON;
        end
    end

    // Data byte
    always_comb
    begin
        data_byte = '0;
        if (link_ready_i && slot[0])
        begin
            data_byte = seg_image[slot[`EVR_SLOT_W-1:1]];  // Odd slot s carries byte s/2
        end
    end

    // Only comma, start and stop go out as K characters
    assign event_is_k = (event_byte == `EVR_K28_5);
    assign data_is_k  = (data_byte == `EVR_SEG_START) || (data_byte == `EVR_SEG_STOP);

    assign tx_word_o = {event_byte, data_byte};
    assign tx_is_k_o = {event_is_k, data_is_k};

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_evr_test_top

verilator --binary --timing --timescale 1ns/10ps -j 0 -f tb.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi
exit 0

/* tb.f */
+incdir+hdl
+incdir+verification
hdl/evr_pkg.sv
hdl/evt_push_if.sv
hdl/link_frame_gen.sv
hdl/evt_prescaler.sv
hdl/evt_fifo.sv
hdl/evr_test_top.sv
verification/tb_evr_test_top.sv

/* verification/tb_evr_model.svh */
`ifndef TB_EVR_MODEL_SVH
`define TB_EVR_MODEL_SVH

// Reference model of the link stream and the event path

// Segment image as the link should carry it
localparam link_byte_t seg_img [32] = '{
    8'h5C, 8'hFF,
    8'h00, 8'h8B, 8'hFC, 8'h7B, 8'h00, 8'h00, 8'h00, 8'h07,
    8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h07,
    8'h3C, 8'hFC, 8'hF0,
    8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00
};

slot_t     m_slot = '0;   // Shadow slot counter
presc_t    m_cnt  = '0;
evt_code_t m_code = '0;   // Next code to be pushed
evt_code_t m_q [$];       // FIFO contents with the head at index 0
int        errors = 0;

// Word expected on the link for a given slot
function automatic link_word_t exp_word(input logic link, input slot_t s);
    link_byte_t hi;
    link_byte_t lo;
    hi = 8'h00;
    lo = 8'h00;
    if (link)
    begin
        if (int'(s) % `EVR_COMMA_PERIOD == 0)
            hi = 8'hBC;
        else if (int'(s) % `EVR_BEACON_PERIOD == 0)
            hi = 8'h7E;
        if (s[0])
            lo = seg_img[s[5:1]];  // Odd slots carry the image
    end
    return {hi, lo};
endfunction

function automatic link_k_t exp_k(input link_word_t w);
    return {w[15:8] == 8'hBC, (w[7:0] == 8'h5C) || (w[7:0] == 8'h3C)};
endfunction

// One clock edge of the model with the inputs held before the edge
task automatic model_step(input logic link, input logic clr, input logic pop_req,
                          input presc_t presc_v);
    logic full;
    full   = (m_q.size() == `EVR_FIFO_DEPTH);
    m_slot = link ? slot_t'(m_slot + 6'd1) : slot_t'(0);
    if (clr)
    begin
        m_cnt  = '0;
        m_code = '0;
        m_q.delete();
    end
    else
    begin
        if (pop_req && m_q.size() != 0)
            void'(m_q.pop_front());
        if (!full)  // Counter stalls under back-pressure
        begin
            if (m_cnt == presc_v)
            begin
                m_q.push_back(m_code);
                m_code = m_code + 8'd1;
                m_cnt  = '0;
            end
            else
                m_cnt = m_cnt + 16'd1;
        end
    end
endtask

task automatic check(input string name, input logic [31:0] expected,
                     input logic [31:0] actual);
    if (expected !== actual)
    begin
        $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        errors = errors + 1;
    end
endtask

`endif

/* verification/tb_evr_test_top.sv */
`timescale 1ns/10ps

`include "evr_defs.svh"

module tb_evr_test_top;

    import evr_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int STREAM_CYCLES  = 200;
    localparam int RESTART_CYCLES = 150;
    localparam int ORDER_CYCLES   = 300;
    localparam int FILL_CYCLES    = `EVR_FIFO_DEPTH * 8;  // Slowest prescaler setting
    localparam int HOLD_CYCLES    = 30;
    localparam int DRAIN_CYCLES   = 200;
    localparam int CLEAR_CYCLES   = 100;
    localparam int RUN_CYCLES     = RESET_CYCLES + 2 + STREAM_CYCLES + RESTART_CYCLES + 4
                                  + 1 + ORDER_CYCLES + FILL_CYCLES + HOLD_CYCLES
                                  + DRAIN_CYCLES + 16 + 1 + CLEAR_CYCLES;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        link_ready;
    logic        clear;
    logic        pop;
    presc_t      presc;
    link_word_t  tx_word;
    link_k_t     tx_is_k;
    evt_code_t   evt_code;
    logic        evt_empty;
    fifo_level_t evt_level;
    evt_code_t   evt_next;

    logic [31:0] lfsr = 32'h4175_39e8;
    evt_code_t   exp_pop = '0;   // Next code the host should see
    int          ticks = 0;
    int          cycles = 0;
    string       test_name = "reset";

    `include "tb_evr_model.svh"

    evr_test_top dut
    (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .link_ready_i (link_ready),
        .clear_i      (clear),
        .presc_i      (presc),
        .pop_i        (pop),
        .tx_word_o    (tx_word),
        .tx_is_k_o    (tx_is_k),
        .evt_code_o   (evt_code),
        .evt_empty_o  (evt_empty),
        .evt_level_o  (evt_level),
        .evt_next_o   (evt_next)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout, the test sequence did not finish within %0d cycles",
                     TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic compare_outputs();
        check({test_name, ".tx_word"}, 32'(exp_word(link_ready, m_slot)), 32'(tx_word));
        check({test_name, ".tx_is_k"}, 32'(exp_k(exp_word(link_ready, m_slot))), 32'(tx_is_k));
        check({test_name, ".evt_level"}, 32'(m_q.size()), 32'(evt_level));
        check({test_name, ".evt_empty"}, 32'(m_q.size() == 0), 32'(evt_empty));
        check({test_name, ".evt_next"}, 32'(m_code), 32'(evt_next));
        if (m_q.size() != 0)
            check({test_name, ".evt_head"}, 32'(m_q[0]), 32'(evt_code));
    endtask

    // Step the model over the rising edge and compare once the DUT has settled
    task automatic tick();
        model_step(link_ready, clear, pop, presc);
        @(negedge clk);
        ticks = ticks + 1;
        compare_outputs();
    endtask

    task automatic drive_pop(input logic want);
        if (want && !evt_empty)
        begin
            check({test_name, ".pop_code"}, 32'(exp_pop), 32'(evt_code));
            exp_pop = exp_pop + 8'd1;
            pop     = 1'b1;
        end
        else
            pop = 1'b0;
    endtask

    initial
    begin
        int        start;
        int        drop_len;
        int        drops;
        int        last_fall;
        logic      prev_empty;
        evt_code_t held;
        drops      = 0;
        arst_n     = 1'b0;
        link_ready = 1'b0;
        clear      = 1'b0;
        pop        = 1'b0;
        presc      = 16'hFFFF;  // Keeps the event path quiet until needed
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        compare_outputs();
        repeat (2) tick();

        test_name  = "link_stream";
        link_ready = 1'b1;
        repeat (STREAM_CYCLES) tick();

        test_name = "link_restart";
        start     = ticks;
        while (ticks - start < RESTART_CYCLES)
        begin
            tick();
            if (rand_bits(4) == 32'd0)
            begin
                drop_len   = 1 + int'(rand_bits(2) % 32'd3);
                drops      = drops + 1;
                link_ready = 1'b0;
                repeat (drop_len) tick();
                link_ready = 1'b1;
                tick();
                // Slot 1 after a restart carries the segment start
                check("link_restart.first_word", 32'h005C, 32'(tx_word));
            end
        end
        check("link_restart.drops_seen", 32'd1, 32'(drops != 0));

        test_name = "event_order";
        presc     = presc_t'(rand_bits(3));
        clear     = 1'b1;  // Count restarts from 0 with the new setting
        tick();
        clear     = 1'b0;
        exp_pop   = '0;
        last_fall = -1;
        repeat (ORDER_CYCLES)
        begin
            drive_pop(1'b1);
            prev_empty = evt_empty;
            tick();
            if (prev_empty && !evt_empty)
            begin
                if (last_fall >= 0)
                    check("event_order.fall_spacing", 32'(presc) + 32'd1,
                          32'(ticks - last_fall));
                last_fall = ticks;
            end
        end

        test_name = "back_pressure";
        pop       = 1'b0;
        while (evt_level != 5'd16)
            tick();
        held = m_code;
        repeat (HOLD_CYCLES)
        begin
            tick();
            check("back_pressure.level", 32'd16, 32'(evt_level));
            check("back_pressure.next_held", 32'(held), 32'(evt_next));
        end
        test_name = "drain";
        repeat (DRAIN_CYCLES)
        begin
            drive_pop(rand_bits(1) != 32'd0);
            tick();
        end

        test_name = "clear";
        pop       = 1'b0;
        while (evt_level < 5'd2)
            tick();
        clear = 1'b1;
        tick();
        clear = 1'b0;
        check("clear.level", 32'd0, 32'(evt_level));
        check("clear.empty", 32'd1, 32'(evt_empty));
        check("clear.next", 32'd0, 32'(evt_next));
        exp_pop = '0;
        repeat (CLEAR_CYCLES)
        begin
            drive_pop(1'b1);
            tick();
        end
        check("clear.popped_any", 32'd1, 32'(exp_pop != 8'd0));

        $display("Test sequence done after %0d cycles, %0d errors", ticks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
